/* hdl/cpuBusPkg.sv */
package cpuBusPkg;

	// one machine word, also the width of the shared bus
	localparam int dataWidth = 32;

	// sixteen general registers
	localparam int regIndexWidth = 4;

	// every source that may drive the shared bus
	// only one is selected per step, so drivers never collide
	typedef enum logic [3:0] {
		busFromGpr    = 4'd0,
		busFromPc     = 4'd1,
		busFromIr     = 4'd2,
		busFromZHigh  = 4'd3,
		busFromZLow   = 4'd4,
		busFromHi     = 4'd5,
		busFromLo     = 4'd6,
		busFromMdr    = 4'd7,
		busFromInPort = 4'd8,
		busFromConst  = 4'd9,
		// nothing selected, bus reads zero
		busIdle       = 4'd10
	} busSourceT;

endpackage

/* hdl/aluOpPkg.sv */
package aluOpPkg;

	// full ALU result, wide enough for a 32x32 product
	localparam int productWidth = 64;

	typedef enum logic [2:0] {
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluAnd   = 3'd2,
		aluOr    = 3'd3,
		aluShl   = 3'd4,
		aluShr   = 3'd5,
		aluMul   = 3'd6,
		// bus plus one, used to step the PC
		aluIncPc = 3'd7
	} aluOpT;

endpackage

/* hdl/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
	input  logic                           clock,
	input  logic                           rstN,
	input  logic [cpuBusPkg::dataWidth-1:0] ir,
	input  logic                           gra,
	input  logic                           grb,
	input  logic                           grc,
	input  logic                           rIn,
	input  logic                           baOut,
	input  logic [cpuBusPkg::dataWidth-1:0] busIn,
	output logic [cpuBusPkg::dataWidth-1:0] gprOut,
	output logic [cpuBusPkg::dataWidth-1:0] constOut
);
	import cpuBusPkg::*;

	localparam int regCount = 1 << regIndexWidth;

	logic [dataWidth-1:0]     regs [regCount];
	logic [regIndexWidth-1:0] regSel;

	// register number taken from the IR fields, ra first
	always_comb begin
		if (gra) begin
			regSel = ir[26:23];
		end else if (grb) begin
			regSel = ir[22:19];
		end else if (grc) begin
			regSel = ir[18:15];
		end else begin
			regSel = '0;
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (rIn) begin
			regs[regSel] <= busIn;
		end
	end

	// base-address mode: R0 stands for a zero base
	assign gprOut = (baOut && regSel == '0) ? '0 : regs[regSel];

	// 19-bit constant field, sign extended to a word
	assign constOut = {{(dataWidth - 19){ir[18]}}, ir[18:0]};

endmodule

/* hdl/busMux.sv */
`timescale 1ns/1ps

module busMux (
	input  cpuBusPkg::busSourceT            busSel,
	input  logic [cpuBusPkg::dataWidth-1:0] gprOut,
	input  logic [cpuBusPkg::dataWidth-1:0] pc,
	input  logic [cpuBusPkg::dataWidth-1:0] ir,
	input  logic [cpuBusPkg::dataWidth-1:0] zHigh,
	input  logic [cpuBusPkg::dataWidth-1:0] zLow,
	input  logic [cpuBusPkg::dataWidth-1:0] hi,
	input  logic [cpuBusPkg::dataWidth-1:0] lo,
	input  logic [cpuBusPkg::dataWidth-1:0] mdr,
	input  logic [cpuBusPkg::dataWidth-1:0] inPort,
	input  logic [cpuBusPkg::dataWidth-1:0] constIn,
	output logic [cpuBusPkg::dataWidth-1:0] busOut
);
	import cpuBusPkg::*;

	// encoded select, so at most one source reaches the bus
	always_comb begin
		case (busSel)
			busFromGpr:    busOut = gprOut;
			busFromPc:     busOut = pc;
			busFromIr:     busOut = ir;
			busFromZHigh:  busOut = zHigh;
			busFromZLow:   busOut = zLow;
			busFromHi:     busOut = hi;
			busFromLo:     busOut = lo;
			busFromMdr:    busOut = mdr;
			busFromInPort: busOut = inPort;
			busFromConst:  busOut = constIn;
			// busIdle and unused codes
			default:       busOut = '0;
		endcase
	end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
	input  aluOpPkg::aluOpT                    aluOp,
	input  logic [cpuBusPkg::dataWidth-1:0]    y,
	input  logic [cpuBusPkg::dataWidth-1:0]    busIn,
	output logic [aluOpPkg::productWidth-1:0]  result
);
	import cpuBusPkg::*;
	import aluOpPkg::*;

	localparam int padWidth = productWidth - dataWidth;

	logic [dataWidth-1:0]           wordResult;
	logic signed [productWidth-1:0] product;
	logic [4:0]                     shiftAmt;

	// only the low five bits of B count for shifts
	assign shiftAmt = busIn[4:0];

	// both operands signed, so they extend by sign to the full width
	assign product = $signed(y) * $signed(busIn);

	always_comb begin
		case (aluOp)
			aluAdd:   wordResult = y + busIn;
			aluSub:   wordResult = y - busIn;
			aluAnd:   wordResult = y & busIn;
			aluOr:    wordResult = y | busIn;
			aluShl:   wordResult = y << shiftAmt;
			aluShr:   wordResult = y >> shiftAmt;
			aluIncPc: wordResult = busIn + 1'b1;
			default:  wordResult = '0;
		endcase
	end

	// word results are zero extended, the product uses all 64 bits
	always_comb begin
		if (aluOp == aluMul) begin
			result = product;
		end else begin
			result = {{padWidth{1'b0}}, wordResult};
		end
	end

endmodule

/* hdl/memoryUnit.sv */
`timescale 1ns/1ps

module memoryUnit #(
	parameter int ramAddrWidth = 9
) (
	input  logic                            clock,
	input  logic                            rstN,
	input  logic                            marIn,
	input  logic                            mdrIn,
	input  logic                            mdRead,
	input  logic                            memWrite,
	input  logic [cpuBusPkg::dataWidth-1:0] busIn,
	output logic [cpuBusPkg::dataWidth-1:0] mdrOut
);
	import cpuBusPkg::*;

	localparam int ramDepth = 1 << ramAddrWidth;

	logic [dataWidth-1:0]    ram [ramDepth];
	logic [ramAddrWidth-1:0] mar;
	logic [dataWidth-1:0]    mdr;
	logic [dataWidth-1:0]    ramData;

	// word addressed, upper bus bits are dropped
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			mar <= '0;
		end else if (marIn) begin
			mar <= busIn[ramAddrWidth-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (memWrite) begin
			ram[mar] <= busIn;
		end
	end

	// asynchronous read of the addressed word
	assign ramData = ram[mar];

	// mdRead picks memory over the bus as the MDR source
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			mdr <= '0;
		end else if (mdrIn) begin
			mdr <= mdRead ? ramData : busIn;
		end
	end

	assign mdrOut = mdr;

endmodule

/* hdl/conditionFlop.sv */
`timescale 1ns/1ps

module conditionFlop (
	input  logic                            clock,
	input  logic                            rstN,
	input  logic                            conIn,
	input  logic [1:0]                      cond,
	input  logic [cpuBusPkg::dataWidth-1:0] busIn,
	output logic                            conFlag
);
	import cpuBusPkg::*;

	logic isZero;
	logic isNeg;
	logic condMet;

	assign isZero = (busIn == '0);
	assign isNeg  = busIn[dataWidth-1];

	// zero, nonzero, non-negative, negative
	always_comb begin
		case (cond)
			2'd0:    condMet = isZero;
			2'd1:    condMet = !isZero;
			2'd2:    condMet = !isNeg;
			default: condMet = isNeg;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			conFlag <= 1'b0;
		end else if (conIn) begin
			conFlag <= condMet;
		end
	end

endmodule

/* hdl/dataPath.sv */
`timescale 1ns/1ps

module dataPath #(
	parameter int ramAddrWidth = 9
) (
	input  logic                            clock,
	input  logic                            rstN,
	input  cpuBusPkg::busSourceT            busSel,
	input  aluOpPkg::aluOpT                 aluOp,
	input  logic                            pcIn,
	input  logic                            irIn,
	input  logic                            yIn,
	input  logic                            zIn,
	input  logic                            hiIn,
	input  logic                            loIn,
	input  logic                            marIn,
	input  logic                            mdrIn,
	input  logic                            outPortIn,
	input  logic                            conIn,
	input  logic                            mdRead,
	input  logic                            memWrite,
	input  logic                            gra,
	input  logic                            grb,
	input  logic                            grc,
	input  logic                            rIn,
	input  logic                            baOut,
	input  logic                            strobe,
	input  logic [cpuBusPkg::dataWidth-1:0] inPortData,
	output logic [cpuBusPkg::dataWidth-1:0] busValue,
	output logic [cpuBusPkg::dataWidth-1:0] outPortData,
	output logic                            conFlag
);
	import cpuBusPkg::*;
	import aluOpPkg::*;

	logic [dataWidth-1:0]    pc, ir, y, hi, lo;
	logic [dataWidth-1:0]    zHigh, zLow;
	logic [dataWidth-1:0]    inPort;
	logic [dataWidth-1:0]    gprOut, constOut, mdrOut;
	logic [productWidth-1:0] aluResult;

	// every load samples the bus at the edge that ends the step
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			pc          <= '0;
			ir          <= '0;
			y           <= '0;
			hi          <= '0;
			lo          <= '0;
			zHigh       <= '0;
			zLow        <= '0;
			inPort      <= '0;
			outPortData <= '0;
		end else begin
			if (pcIn) pc <= busValue;
			if (irIn) ir <= busValue;
			if (yIn) y <= busValue;
			if (hiIn) hi <= busValue;
			if (loIn) lo <= busValue;
			// Z takes both halves of the ALU result together
			if (zIn) begin
				zHigh <= aluResult[productWidth-1:dataWidth];
				zLow  <= aluResult[dataWidth-1:0];
			end
			// input port latches the external word, not the bus
			if (strobe) inPort <= inPortData;
			if (outPortIn) outPortData <= busValue;
		end
	end

	registerFile gprs (
		.clock(clock), .rstN(rstN), .ir(ir),
		.gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .baOut(baOut),
		.busIn(busValue), .gprOut(gprOut), .constOut(constOut)
	);

	busMux bus (
		.busSel(busSel), .gprOut(gprOut), .pc(pc), .ir(ir),
		.zHigh(zHigh), .zLow(zLow), .hi(hi), .lo(lo), .mdr(mdrOut),
		.inPort(inPort), .constIn(constOut), .busOut(busValue)
	);

	alu aluUnit (.aluOp(aluOp), .y(y), .busIn(busValue), .result(aluResult));

	memoryUnit #(.ramAddrWidth(ramAddrWidth)) mem (
		.clock(clock), .rstN(rstN), .marIn(marIn), .mdrIn(mdrIn),
		.mdRead(mdRead), .memWrite(memWrite), .busIn(busValue), .mdrOut(mdrOut)
	);

	// branch condition sits in IR bits 20 to 19
	conditionFlop con (
		.clock(clock), .rstN(rstN), .conIn(conIn), .cond(ir[20:19]),
		.busIn(busValue), .conFlag(conFlag)
	);

endmodule

/* tb/dataPath_assert.sv */
`timescale 1ns/1ps

module dataPathAssert (
	input logic                            clock,
	input logic                            rstN,
	input logic                            outPortIn,
	input logic                            conIn,
	input cpuBusPkg::busSourceT            busSel,
	input logic [cpuBusPkg::dataWidth-1:0] busValue,
	input logic [cpuBusPkg::dataWidth-1:0] outPortData,
	input logic                            conFlag
);
	import cpuBusPkg::*;

	int failCount = 0;

	// output port only changes on a load step
	outPortHold: assert property (@(posedge clock) disable iff (!rstN)
		!outPortIn |=> $stable(outPortData))
		else begin
			failCount++;
			$error("outPortData changed without outPortIn");
		end

	conFlagHold: assert property (@(posedge clock) disable iff (!rstN)
		!conIn |=> $stable(conFlag))
		else begin
			failCount++;
			$error("conFlag changed without conIn");
		end

	// an idle bus carries zero
	idleBusZero: assert property (@(posedge clock) disable iff (!rstN)
		busSel == busIdle |-> busValue == '0)
		else begin
			failCount++;
			$error("bus not zero while idle");
		end

endmodule

bind dataPath dataPathAssert rules (
	.clock(clock), .rstN(rstN), .outPortIn(outPortIn), .conIn(conIn),
	.busSel(busSel), .busValue(busValue), .outPortData(outPortData),
	.conFlag(conFlag)
);

/* tb/dataPathTb.sv */
`timescale 1ns/1ps

module dataPathTb;
	import cpuBusPkg::*;
	import aluOpPkg::*;

	localparam int ramAddrWidth = 9;
	localparam int resetCycles = 3;
	localparam time clockPeriod = 100ns;

	logic clock, rstN;
	busSourceT busSel;
	aluOpT aluOp;
	logic pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn, conIn;
	logic mdRead, memWrite, gra, grb, grc, rIn, baOut, strobe;
	logic [dataWidth-1:0] inPortData, busValue, outPortData;
	logic conFlag;

	// one entry per pattern line
	string stepNames[$];
	logic [31:0] ctrlWords[$];
	logic [dataWidth-1:0] inWords[$], expBus[$], expOut[$];
	logic expCon[$];
	bit hasBus[$], hasOut[$], hasCon[$];

	int valueErrors = 0;
	int otherErrors = 0;
	int cycleCount = 0;
	int cycleLimit = 1000;

	dataPath #(.ramAddrWidth(ramAddrWidth)) u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	task automatic checkWord(input string testName, input string what,
			input logic [dataWidth-1:0] expected, input logic [dataWidth-1:0] actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("ERR %s %s expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic checkFlag(input string testName, input string what,
			input logic expected, input logic actual);
		if (actual !== expected) begin
			valueErrors++;
			$display("ERR %s %s expected %b actual %b", testName, what, expected, actual);
		end
	endtask

	// unpack a control word by the bit layout of the pattern file
	task automatic applyControl(input logic [31:0] w, input logic [dataWidth-1:0] inWord);
		busSel = busSourceT'(w[3:0]);
		aluOp = aluOpT'(w[6:4]);
		pcIn = w[7];
		irIn = w[8];
		yIn = w[9];
		zIn = w[10];
		hiIn = w[11];
		loIn = w[12];
		marIn = w[13];
		mdrIn = w[14];
		outPortIn = w[15];
		conIn = w[16];
		mdRead = w[17];
		memWrite = w[18];
		gra = w[19];
		grb = w[20];
		grc = w[21];
		rIn = w[22];
		baOut = w[23];
		strobe = w[24];
		inPortData = inWord;
	endtask

	task automatic readPatterns();
		int fd;
		int code;
		string tok, line, sBus, sOut, sCon;
		logic [31:0] ctrl, inV, v;
		fd = $fopen("tb/dataPathPatterns.txt", "r");
		if (fd == 0) begin
			otherErrors++;
			$display("could not open the pattern file");
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) break;
			if (tok.substr(0, 0) == "#") begin
				void'($fgets(line, fd));
				continue;
			end
			code = $fscanf(fd, "%h %h %s %s %s", ctrl, inV, sBus, sOut, sCon);
			if (code != 5) begin
				otherErrors++;
				$display("pattern line %s is malformed", tok);
				break;
			end
			stepNames.push_back(tok);
			ctrlWords.push_back(ctrl);
			inWords.push_back(inV);
			hasBus.push_back(sBus != "-");
			hasOut.push_back(sOut != "-");
			hasCon.push_back(sCon != "-");
			v = '0;
			if (sBus != "-") void'($sscanf(sBus, "%h", v));
			expBus.push_back(v);
			v = '0;
			if (sOut != "-") void'($sscanf(sOut, "%h", v));
			expOut.push_back(v);
			v = '0;
			if (sCon != "-") void'($sscanf(sCon, "%h", v));
			expCon.push_back(v[0]);
		end
		$fclose(fd);
	endtask

	task automatic finishRun();
		int assertErrors;
		assertErrors = u_dut.rules.failCount;
		$display("errors: %0d value mismatches, %0d assertion failures, %0d other",
			valueErrors, assertErrors, otherErrors);
		if (valueErrors == 0 && assertErrors == 0 && otherErrors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	endtask

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			otherErrors++;
			$display("the run timed out after %0d cycles", cycleLimit);
			finishRun();
		end
	end

	initial begin
		rstN = 1'b0;
		applyControl({28'd0, 4'd10}, '0);
		readPatterns();
		cycleLimit = stepNames.size() + resetCycles + 20;
		repeat (resetCycles) @(posedge clock);
		#1ns rstN = 1'b1;
		foreach (stepNames[i]) begin
			@(posedge clock);
			#1ns applyControl(ctrlWords[i], inWords[i]);
			// sample mid cycle well after the drive
			#(clockPeriod / 2);
			if (hasBus[i]) checkWord(stepNames[i], "bus", expBus[i], busValue);
			if (hasOut[i]) checkWord(stepNames[i], "outPort", expOut[i], outPortData);
			if (hasCon[i]) checkFlag(stepNames[i], "conFlag", expCon[i], conFlag);
		end
		@(posedge clock);
		#1ns;
		finishRun();
	end

endmodule

/* tb/dataPathPatterns.txt */
# name ctrl inPortData expBus expOutPort expConFlag, hex, - skips a check
# ctrl bits: 3:0 busSel 6:4 aluOp 7 pcIn 8 irIn 9 yIn 10 zIn 11 hiIn 12 loIn 13 marIn
# 14 mdrIn 15 outPortIn 16 conIn 17 mdRead 18 memWrite 19 gra 20 grb 21 grc 22 rIn 23 baOut 24 strobe
resetPc 0000001 00000000 00000000 00000000 0
xferStrobeIr 100000A 02800000 00000000 00000000 0
xferLoadIr 0000108 00000000 02800000 - -
xferStrobeVal 100000A CAFE1234 00000000 - -
xferWriteR5 0480008 00000000 CAFE1234 - -
xferReadR5 0080000 00000000 CAFE1234 - -
baStrobeIr 100000A 00280000 00000000 - -
baLoadIr 0000108 00000000 00280000 - -
baStrobeVal 100000A 5A5A0001 00000000 - -
baWriteR0 0480008 00000000 5A5A0001 - -
baReadR0Masked 0880000 00000000 00000000 - -
baReadR0Plain 0080000 00000000 5A5A0001 - -
baReadR5 0900000 00000000 CAFE1234 - -
aluLoadY 0100200 00000000 CAFE1234 - -
aluAdd 0080400 00000000 5A5A0001 - -
aluAddLow 0000004 00000000 25581235 - -
aluAddHigh 0000003 00000000 00000000 - -
aluSub 0080410 00000000 5A5A0001 - -
aluSubLow 0000004 00000000 70A41233 - -
aluAnd 0080420 00000000 5A5A0001 - -
aluAndLow 0000004 00000000 4A5A0000 - -
aluOr 0080430 00000000 5A5A0001 - -
aluOrLow 0000004 00000000 DAFE1235 - -
aluShl 0080440 00000000 5A5A0001 - -
aluShlLow 0000004 00000000 95FC2468 - -
aluShr 0080450 00000000 5A5A0001 - -
aluShrLow 0000004 00000000 657F091A - -
aluInc 0080470 00000000 5A5A0001 - -
aluIncLow 0000004 00000000 5A5A0002 - -
mulStrobeY 100000A FFFFFFFD 00000000 - -
mulLoadY 1000208 00000007 FFFFFFFD - -
mulRun 0000468 00000000 00000007 - -
mulLow 0000004 00000000 FFFFFFEB - -
mulHigh 0000003 00000000 FFFFFFFF - -
memStrobeA 100000A 00000010 00000000 - -
memMarA 1002008 11112222 00000010 - -
memWriteA 1040008 00000011 11112222 - -
memMarB 1002008 33334444 00000011 - -
memWriteB 1040008 00000010 33334444 - -
memMarRdA 0002008 00000000 00000010 - -
memMdrRdA 002400A 00000000 00000000 - -
memReadA 0000007 00000000 11112222 - -
memStrobeB 100000A 00000011 00000000 - -
memMarRdB 0002008 00000000 00000011 - -
memMdrRdB 002400A 00000000 00000000 - -
memReadB 0000007 00000000 33334444 - -
c0Strobe 100000A 00000000 00000000 00000000 0
c0LoadIr 0000108 00000000 00000000 00000000 0
c0Zero 001000A 00000000 00000000 00000000 0
c0Pos 0090000 00000000 5A5A0001 00000000 1
c1Strobe 100000A 00080000 00000000 00000000 0
c1LoadIr 0000108 00000000 00080000 00000000 0
c1Pos 0090000 00000000 5A5A0001 00000000 0
c1Zero 001000A 00000000 00000000 00000000 1
c2Strobe 100000A 00100000 00000000 00000000 0
c2LoadIr 0000108 00000000 00100000 00000000 0
c2Neg 0010004 00000000 FFFFFFEB 00000000 0
c2Zero 001000A 00000000 00000000 00000000 0
c3Strobe 100000A 00180000 00000000 00000000 1
c3LoadIr 0000108 00000000 00180000 00000000 1
c3Neg 0010004 00000000 FFFFFFEB 00000000 1
c3Pos 0090000 00000000 5A5A0001 00000000 1
outLoad 0008004 00000000 FFFFFFEB 00000000 0
outCheck 000000A 00000000 00000000 FFFFFFEB 0

/* dataPath.f */
hdl/cpuBusPkg.sv
hdl/aluOpPkg.sv
hdl/registerFile.sv
hdl/busMux.sv
hdl/alu.sv
hdl/memoryUnit.sv
hdl/conditionFlop.sv
hdl/dataPath.sv
tb/dataPath_assert.sv
tb/dataPathTb.sv
